// File: tb.f
+incdir+logic
logic/shifter_regs_pkg.sv
logic/shifter_timing_pkg.sv
logic/video_regs.sv
logic/video_timing.sv
logic/video_fetch.sv
logic/plane_shifter.sv
logic/shifter_top.sv
sim/tb_clock.sv
sim/shifter_checker.sv
sim/shifter_tb.sv

// File: Makefile
# video shifter simulation with Verilator

TOP = shifter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: sim/shifter_tb.sv
// video shifter testbench
// directed tests for the register bus and the three shift modes,
// with a req/ack memory model and a cycle limit
`timescale 1ns/100ps
`include "shifter_defines.svh"

module shifter_tb import shifter_regs_pkg::*; ();

	// one low res frame is 56 pixels x 10 lines x 4 clk
	localparam int LOW_FRAME_CLK = 56 * 10 * 4;
	// about eight low res frames, the longest waits plus register tests
	localparam int CYCLE_LIMIT   = 8 * LOW_FRAME_CLK + 2080;
	localparam int MEM_DEPTH     = 1024;
	localparam logic [`VADDR_W-1:0] MEM_BASE = 23'h008000;

	logic                clk;
	logic                cpu_reset;
	logic                cpu_sel;
	logic                cpu_rw;
	logic [5:0]          cpu_addr;
	logic [15:0]         cpu_din;
	logic                cpu_uds;
	logic                cpu_lds;
	logic [15:0]         cpu_dout;
	logic                mem_req;
	logic [`VADDR_W-1:0] mem_addr;
	logic                mem_ack = 1'b0;
	logic [`WORD_W-1:0]  mem_data = '0;
	logic                hs;
	logic                vs;
	logic                display_enable;
	logic                pixel_strobe;
	logic [3:0]          video_r;
	logic [3:0]          video_g;
	logic [3:0]          video_b;

	logic [15:0] mem [MEM_DEPTH];
	// expected palette, {r, g, b}
	logic [8:0]  pal_model [16];
	logic [31:0] rng;
	int          value_errors;
	int          other_errors;
	int          cycles;

	tb_clock u_clock (.clk(clk));

	shifter_top UUT (
		.clk, .cpu_reset, .cpu_sel, .cpu_rw, .cpu_addr, .cpu_din, .cpu_uds, .cpu_lds,
		.cpu_dout, .mem_req, .mem_addr, .mem_ack, .mem_data, .hs, .vs,
		.display_enable, .pixel_strobe, .video_r, .video_g, .video_b
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// words outside the array fold the whole address
	function automatic logic [15:0] mem_word(input logic [`VADDR_W-1:0] addr);
		logic [`VADDR_W-1:0] ofs;
		ofs = addr - MEM_BASE;
		if (ofs < MEM_DEPTH)
			return mem[ofs[9:0]];
		return addr[15:0] ^ {9'h000, addr[22:16]};
	endfunction

	// palette entry as the bus shows it
	function automatic logic [15:0] palette_word(input int idx);
		logic [8:0] e;
		e = pal_model[idx];
		return {5'h00, e[8:6], 1'b0, e[5:3], 1'b0, e[2:0]};
	endfunction

	// pixel k of the frame, 32 per line, 2 groups of 16 per line
	function automatic logic [11:0] expected_pixel(input shift_mode_t mode,
			input logic [`VADDR_W-1:0] base, input int k);
		int         line;
		int         x;
		int         planes;
		int         group;
		logic [3:0] idx;
		logic [15:0] w;
		logic [8:0] e;
		line   = k / 32;
		x      = k % 32;
		planes = (mode == SM_LOW) ? 4 : (mode == SM_MID) ? 2 : 1;
		group  = line * 2 + x / 16;
		idx    = 4'h0;
		for (int p = 0; p < planes; p++) begin
			w      = mem_word(base + 23'(group * planes + p));
			idx[p] = w[15 - x % 16];
		end
		if (mode == SM_MONO)
			return {12{idx[0] ^ pal_model[0][0]}};
		e = pal_model[idx];
		return {e[8:6], e[8], e[5:3], e[5], e[2:0], e[2]};
	endfunction

	task automatic report_mismatch(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		value_errors++;
		$display("FAIL %s: %s expected %h actual %h", test, what, expected, actual);
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("ERROR: %s", msg);
	endtask

	// one bus cycle, strobes active low
	task automatic write_reg(input logic [5:0] addr, input logic [15:0] data,
			input logic uds, input logic lds);
		@(posedge clk);
		cpu_sel  <= 1'b1;
		cpu_rw   <= 1'b0;
		cpu_addr <= addr;
		cpu_din  <= data;
		cpu_uds  <= uds;
		cpu_lds  <= lds;
		@(posedge clk);
		cpu_sel <= 1'b0;
		cpu_rw  <= 1'b1;
		cpu_uds <= 1'b1;
		cpu_lds <= 1'b1;
	endtask

	task automatic read_reg(input logic [5:0] addr, output logic [15:0] data);
		@(posedge clk);
		cpu_sel  <= 1'b1;
		cpu_rw   <= 1'b1;
		cpu_addr <= addr;
		@(negedge clk);
		data = cpu_dout;
		@(posedge clk);
		cpu_sel <= 1'b0;
	endtask

	task automatic write_palette(input int idx, input logic [15:0] data,
			input logic uds, input logic lds);
		write_reg(6'(`PAL_FIRST + idx), data, uds, lds);
		// red rides in the upper byte, green and blue in the lower
		if (!uds)
			pal_model[idx][8:6] = data[10:8];
		if (!lds)
			pal_model[idx][5:0] = {data[6:4], data[2:0]};
	endtask

	task automatic set_base(input logic [7:0] hi, input logic [7:0] mid);
		write_reg(`BASE_HI, {8'h00, hi}, 1'b1, 1'b0);
		write_reg(`BASE_MID, {8'h00, mid}, 1'b1, 1'b0);
	endtask

	// a whole vs pulse after the last write, so the reload saw it
	task automatic wait_frame_start();
		@(negedge clk);
		while (vs !== 1'b1)
			@(negedge clk);
		while (vs !== 1'b0)
			@(negedge clk);
		while (vs !== 1'b1)
			@(negedge clk);
	endtask

	// collect 128 display pixels, then none until vertical blank
	task automatic check_frame(input string test, input shift_mode_t mode,
			input logic [`VADDR_W-1:0] base);
		logic [11:0] exp;
		logic [11:0] act;
		int          count;
		int          extra;
		int          period;
		int          gap;
		logic        seen;
		int          falls;
		logic        hs_prev;
		count = 0;
		extra = 0;
		gap   = 0;
		seen  = 1'b0;
		falls = 0;
		// clk per pixel in each mode
		period = (mode == SM_LOW) ? 4 : (mode == SM_MID) ? 2 : 1;
		wait_frame_start();
		while (count < 128) begin
			@(negedge clk);
			gap++;
			if (pixel_strobe) begin
				if (seen && gap != period)
					report_mismatch(test, "strobe period", period, gap);
				seen = 1'b1;
				gap  = 0;
			end
			if (pixel_strobe && display_enable) begin
				exp = expected_pixel(mode, base, count);
				act = {video_r, video_g, video_b};
				if (act !== exp)
					report_mismatch(test, $sformatf("pixel %0d", count), exp, act);
				count++;
			end
		end
		// one hs pulse per line, from the last display line down to vertical blank
		hs_prev = hs;
		while (falls < `V_BLANK_B - `V_DISP_END) begin
			@(negedge clk);
			if (pixel_strobe && display_enable)
				extra++;
			if (hs_prev && !hs)
				falls++;
			hs_prev = hs;
		end
		if (extra != 0)
			report_failure($sformatf("%s: display_enable high for %0d extra pixels", test, extra));
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic reset_defaults();
		logic [15:0] rd;
		@(negedge clk);
		if (mem_req !== 1'b0)
			report_mismatch("reset_defaults", "mem_req", 0, mem_req);
		if (hs !== 1'b1)
			report_mismatch("reset_defaults", "hs", 1, hs);
		if (vs !== 1'b1)
			report_mismatch("reset_defaults", "vs", 1, vs);
		read_reg(`BASE_HI, rd);
		if (rd !== 16'h0001)
			report_mismatch("reset_defaults", "base hi", 16'h0001, rd);
		read_reg(`BASE_MID, rd);
		if (rd !== 16'h0000)
			report_mismatch("reset_defaults", "base mid", 16'h0000, rd);
		read_reg(`SHMODE, rd);
		if (rd !== {6'h00, SM_MONO, 8'h00})
			report_mismatch("reset_defaults", "shift mode", {6'h00, SM_MONO, 8'h00}, rd);
	endtask

	task automatic register_access();
		logic [15:0] rd;
		write_reg(`BASE_HI, 16'h00ab, 1'b1, 1'b0);
		read_reg(`BASE_HI, rd);
		if (rd !== 16'h00ab)
			report_mismatch("register_access", "base hi", 16'h00ab, rd);
		write_reg(`BASE_MID, 16'h00cd, 1'b1, 1'b0);
		read_reg(`BASE_MID, rd);
		if (rd !== 16'h00cd)
			report_mismatch("register_access", "base mid", 16'h00cd, rd);
		// base lives in the lower byte, upper strobe alone does nothing
		write_reg(`BASE_HI, 16'h1234, 1'b0, 1'b1);
		read_reg(`BASE_HI, rd);
		if (rd !== 16'h00ab)
			report_mismatch("register_access", "base hi after upper write", 16'h00ab, rd);
		write_reg(`SHMODE, {6'h00, SM_MID, 8'h00}, 1'b0, 1'b1);
		read_reg(`SHMODE, rd);
		if (rd !== 16'h0100)
			report_mismatch("register_access", "shift mode", 16'h0100, rd);
		write_reg(`SHMODE, {6'h00, SM_LOW, 8'h00}, 1'b1, 1'b0);
		read_reg(`SHMODE, rd);
		if (rd !== 16'h0100)
			report_mismatch("register_access", "shift mode after lower write", 16'h0100, rd);
		write_reg(`SHMODE, {6'h00, SM_MONO, 8'h00}, 1'b0, 1'b0);
		for (int i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			write_palette(i, rng[15:0], 1'b0, 1'b0);
			read_reg(6'(`PAL_FIRST + i), rd);
			if (rd !== palette_word(i))
				report_mismatch("register_access", $sformatf("palette %0d", i), palette_word(i), rd);
			if ((rd & 16'h0888) != 16'h0000)
				report_failure($sformatf("palette %0d reads a set bit at 3, 7 or 11", i));
			// red only, then green and blue only
			rng = xorshift32(rng);
			write_palette(i, rng[15:0], 1'b0, 1'b1);
			read_reg(6'(`PAL_FIRST + i), rd);
			if (rd !== palette_word(i))
				report_mismatch("register_access", $sformatf("palette %0d upper", i), palette_word(i), rd);
			rng = xorshift32(rng);
			write_palette(i, rng[15:0], 1'b1, 1'b0);
			read_reg(6'(`PAL_FIRST + i), rd);
			if (rd !== palette_word(i))
				report_mismatch("register_access", $sformatf("palette %0d lower", i), palette_word(i), rd);
		end
	endtask

	task automatic mono_frame();
		set_base(8'h01, 8'h01);
		write_reg(`SHMODE, {6'h00, SM_MONO, 8'h00}, 1'b0, 1'b0);
		write_palette(0, 16'h0000, 1'b0, 1'b0);
		check_frame("mono_frame", SM_MONO, {8'h01, 8'h01, 7'h00});
		// blue lsb of entry 0 inverts the picture
		write_palette(0, 16'h0001, 1'b0, 1'b0);
		check_frame("mono_frame_inverted", SM_MONO, {8'h01, 8'h01, 7'h00});
	endtask

	task automatic low_res_frame();
		for (int i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			write_palette(i, rng[15:0], 1'b0, 1'b0);
		end
		set_base(8'h01, 8'h02);
		write_reg(`SHMODE, {6'h00, SM_LOW, 8'h00}, 1'b0, 1'b0);
		check_frame("low_res_frame", SM_LOW, {8'h01, 8'h02, 7'h00});
	endtask

	task automatic mid_res_frame();
		logic [15:0]         rd;
		logic [`VADDR_W-1:0] vexp;
		// 4 lines x 2 groups x 2 planes
		vexp = {8'h01, 8'h03, 7'h00} + 23'(4 * 2 * 2);
		set_base(8'h01, 8'h03);
		write_reg(`SHMODE, {6'h00, SM_MID, 8'h00}, 1'b0, 1'b0);
		check_frame("mid_res_frame", SM_MID, {8'h01, 8'h03, 7'h00});
		// now in vertical blank, before the next reload
		read_reg(`VADDR_HI, rd);
		if (rd !== {8'h00, vexp[22:15]})
			report_mismatch("mid_res_frame", "vaddr hi", {8'h00, vexp[22:15]}, rd);
		read_reg(`VADDR_MID, rd);
		if (rd !== {8'h00, vexp[14:7]})
			report_mismatch("mid_res_frame", "vaddr mid", {8'h00, vexp[14:7]}, rd);
		read_reg(`VADDR_LO, rd);
		if (rd !== {8'h00, vexp[6:0], 1'b0})
			report_mismatch("mid_res_frame", "vaddr lo", {8'h00, vexp[6:0], 1'b0}, rd);
	endtask

	// ----------------------------------------
	// memory model, ack one cycle after req
	// ----------------------------------------
	always @(posedge clk) begin
		if (cpu_reset) begin
			mem_ack <= 1'b0;
		end else if (mem_req && !mem_ack) begin
			mem_ack  <= 1'b1;
			mem_data <= mem_word(mem_addr);
		end else if (!mem_req && mem_ack) begin
			mem_ack <= 1'b0;
		end
	end

	// cycle limit
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		report_failure($sformatf("timeout, no result after %0d cycles", cycles));
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		$display("Testbench failed");
		$finish;
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		value_errors = 0;
		other_errors = 0;
		cpu_reset    = 1'b1;
		cpu_sel      = 1'b0;
		cpu_rw       = 1'b1;
		cpu_addr     = 6'h00;
		cpu_din      = 16'h0000;
		cpu_uds      = 1'b1;
		cpu_lds      = 1'b1;
		rng          = 32'd64708;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			rng    = xorshift32(rng);
			mem[i] = rng[15:0];
		end
		repeat (16) @(posedge clk);
		cpu_reset <= 1'b0;
		reset_defaults();
		register_access();
		mono_frame();
		low_res_frame();
		mid_res_frame();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: sim/shifter_checker.sv
// video shifter protocol checks
// req/ack handshake rules and blanking during sync,
// bound into the top level
`timescale 1ns/100ps

module shifter_checker (
	input logic       clk,
	input logic       cpu_reset,
	input logic       mem_req,
	input logic       mem_ack,
	input logic       hs,
	input logic       vs,
	input logic [3:0] video_r,
	input logic [3:0] video_g,
	input logic [3:0] video_b
);

	// ----------------------------------------
	// memory handshake
	// ----------------------------------------
	// request stays up until the memory answers
	req_holds: assert property (@(posedge clk) disable iff (cpu_reset)
		(mem_req && !mem_ack) |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	// no new request while the old ack is still high
	req_waits_for_ack_low: assert property (@(posedge clk) disable iff (cpu_reset)
		(mem_ack && !mem_req) |=> !mem_req)
		else $error("mem_req rose while mem_ack was high");

	// sync lies inside blank, so rgb is black
	rgb_black_in_sync: assert property (@(posedge clk) disable iff (cpu_reset)
		(!hs || !vs) |-> (video_r == 4'h0 && video_g == 4'h0 && video_b == 4'h0))
		else $error("rgb not black during sync");

endmodule

bind shifter_top shifter_checker u_checker (
	.clk       (clk),
	.cpu_reset (cpu_reset),
	.mem_req   (mem_req),
	.mem_ack   (mem_ack),
	.hs        (hs),
	.vs        (vs),
	.video_r   (video_r),
	.video_g   (video_g),
	.video_b   (video_b)
);

// File: sim/tb_clock.sv
// testbench clock source
// free running clk with a 40 ns period
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	// half of the 40 ns period
	localparam real HALF_PERIOD = 20.0;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: logic/shifter_top.sv
// video shifter top level
// connects registers, timing, fetch engine and pixel path
`timescale 1ns/100ps
`include "shifter_defines.svh"

module shifter_top import shifter_regs_pkg::*; (
	input  logic                clk,
	input  logic                cpu_reset,
	input  logic                cpu_sel,
	input  logic                cpu_rw,
	input  logic [5:0]          cpu_addr,
	input  logic [15:0]         cpu_din,
	input  logic                cpu_uds,
	input  logic                cpu_lds,
	output logic [15:0]         cpu_dout,
	output logic                mem_req,
	output logic [`VADDR_W-1:0] mem_addr,
	input  logic                mem_ack,
	input  logic [`WORD_W-1:0]  mem_data,
	output logic                hs,
	output logic                vs,
	output logic                display_enable,
	output logic                pixel_strobe,
	output logic [3:0]          video_r,
	output logic [3:0]          video_g,
	output logic [3:0]          video_b
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic [`VADDR_W-1:0]     base_addr;
	logic [`VADDR_W-1:0]     vaddr;
	shift_mode_t             shift_mode;
	pal_entry_t              pal_out;
	logic                    pal0_blue_lsb;
	logic [3:0]              color_index;
	logic [`CNT_W-1:0]       hcnt;
	logic                    blank;
	logic                    border;
	logic                    frame_reload;
	logic                    fetch_window;
	logic [3:0][`WORD_W-1:0] plane_words;

	video_regs u_regs (
		.clk, .cpu_reset, .cpu_sel, .cpu_rw, .cpu_addr, .cpu_din, .cpu_uds, .cpu_lds,
		.vaddr, .color_index, .cpu_dout, .base_addr, .shift_mode, .pal_out, .pal0_blue_lsb
	);

	video_timing u_timing (
		.clk, .cpu_reset, .shift_mode, .pixel_strobe, .hcnt, .vcnt(),
		.blank, .border, .hs, .vs, .frame_reload, .fetch_window
	);

	video_fetch u_fetch (
		.clk, .cpu_reset, .shift_mode, .pixel_strobe, .hcnt, .fetch_window, .frame_reload,
		.base_addr, .mem_req, .mem_addr, .vaddr, .mem_ack, .mem_data, .plane_words
	);

	plane_shifter u_shifter (
		.clk, .cpu_reset, .pixel_strobe, .hcnt, .blank, .border, .shift_mode, .plane_words,
		.pal_out, .pal0_blue_lsb, .color_index, .video_r, .video_g, .video_b, .display_enable
	);

endmodule

// File: logic/plane_shifter.sv
// video shifter pixel path
// four plane shift registers, colour index, palette or mono
// output stage registered on the pixel strobe
`timescale 1ns/100ps
`include "shifter_defines.svh"

module plane_shifter import shifter_regs_pkg::*; (
	input  logic                    clk,
	input  logic                    cpu_reset,
	input  logic                    pixel_strobe,
	input  logic [`CNT_W-1:0]       hcnt,
	input  logic                    blank,
	input  logic                    border,
	input  shift_mode_t             shift_mode,
	input  logic [3:0][`WORD_W-1:0] plane_words,
	input  pal_entry_t              pal_out,
	input  logic                    pal0_blue_lsb,
	output logic [3:0]              color_index,
	output logic [3:0]              video_r,
	output logic [3:0]              video_g,
	output logic [3:0]              video_b,
	output logic                    display_enable
);

	logic [3:0][`WORD_W-1:0] shreg;
	logic                    reload;
	logic                    mono_bit;

	// new word shows on the next 16 pixel edge, also after the short line end
	assign reload = (hcnt[3:0] == 4'hf) || (hcnt == `H_END);

	always_ff @(posedge clk) begin
		if (pixel_strobe) begin
			if (reload)
				shreg <= plane_words;
			else
				for (int i = 0; i < 4; i++)
					shreg[i] <= {shreg[i][`WORD_W-2:0], 1'b0};
		end
	end

	// plane 3 is the index msb, border uses entry 0
	assign color_index = border ? 4'd0 :
		{shreg[3][`WORD_W-1], shreg[2][`WORD_W-1], shreg[1][`WORD_W-1], shreg[0][`WORD_W-1]};

	// mono inverts with blue lsb of entry 0
	assign mono_bit = shreg[0][`WORD_W-1] ^ pal0_blue_lsb;

	// ----------------------------------------
	// output stage
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			video_r        <= 4'h0;
			video_g        <= 4'h0;
			video_b        <= 4'h0;
			display_enable <= 1'b0;
		end else if (pixel_strobe) begin
			display_enable <= !blank && !border;
			if (blank) begin
				video_r <= 4'h0;
				video_g <= 4'h0;
				video_b <= 4'h0;
			end else if (shift_mode == SM_MONO) begin
				video_r <= {4{mono_bit}};
				video_g <= {4{mono_bit}};
				video_b <= {4{mono_bit}};
			end else begin
				// 3 to 4 bits, msb repeated as lsb
				video_r <= {pal_out.r, pal_out.r[2]};
				video_g <= {pal_out.g, pal_out.g[2]};
				video_b <= {pal_out.b, pal_out.b[2]};
			end
		end
	end

endmodule

// File: logic/video_fetch.sv
// video shifter fetch engine
// req/ack memory master, video address and plane counters,
// one 16 bit latch per plane
`timescale 1ns/100ps
`include "shifter_defines.svh"

module video_fetch import shifter_regs_pkg::*, shifter_timing_pkg::*; (
	input  logic                   clk,
	input  logic                   cpu_reset,
	input  shift_mode_t            shift_mode,
	input  logic                   pixel_strobe,
	input  logic [`CNT_W-1:0]      hcnt,
	input  logic                   fetch_window,
	input  logic                   frame_reload,
	input  logic [`VADDR_W-1:0]    base_addr,
	output logic                   mem_req,
	output logic [`VADDR_W-1:0]    mem_addr,
	output logic [`VADDR_W-1:0]    vaddr,
	input  logic                   mem_ack,
	input  logic [`WORD_W-1:0]     mem_data,
	output logic [3:0][`WORD_W-1:0] plane_words
);

	plane_idx_t plane;
	plane_idx_t plane_last;
	logic [2:0] words_left;
	logic [3:0] grp_cnt;
	logic       grp_start;
	logic       capture;

	// highest plane number in use
	always_comb begin
		case (shift_mode)
			SM_LOW:  plane_last = 2'd3;
			SM_MID:  plane_last = 2'd1;
			default: plane_last = 2'd0;
		endcase
	end

	// a group starts on every 16th strobe inside the window
	assign grp_start = pixel_strobe && fetch_window && (grp_cnt == 4'd0);
	assign capture   = mem_req && mem_ack;
	// held stable while req is up since vaddr steps only on capture
	assign mem_addr  = vaddr;

	always_ff @(posedge clk) begin
		if (cpu_reset || !fetch_window)
			grp_cnt <= 4'd0;
		else if (pixel_strobe)
			grp_cnt <= grp_cnt + 4'd1;
	end

	// ----------------------------------------
	// four phase master
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			mem_req    <= 1'b0;
			words_left <= 3'd0;
		end else begin
			// late words of the last group are dropped
			if (grp_start)
				words_left <= {1'b0, plane_last} + 3'd1;
			else if (capture)
				words_left <= words_left - 3'd1;
			if (capture)
				mem_req <= 1'b0;
			else if (!mem_req && !mem_ack && words_left != 3'd0)
				mem_req <= 1'b1;
		end
	end

	// address and plane counter, reloaded once per frame
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			vaddr <= `BASE_RESET;
			plane <= 2'd0;
		end else if (frame_reload) begin
			vaddr <= base_addr;
			plane <= 2'd0;
		end else if (capture) begin
			vaddr <= vaddr + 23'd1;
			plane <= (plane == plane_last) ? 2'd0 : plane + 2'd1;
		end
	end

	// steer each word to its plane, unused planes stay 0
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (plane_idx_t'(i) > plane_last)
				plane_words[i] <= '0;
			else if (capture && plane == plane_idx_t'(i))
				plane_words[i] <= mem_data;
		end
	end

endmodule

// File: logic/video_timing.sv
// video shifter timing generator
// pixel strobe per mode, h/v counters, sync, blank, border
// and the fetch window that leads each display line
`timescale 1ns/100ps
`include "shifter_defines.svh"

module video_timing import shifter_regs_pkg::*, shifter_timing_pkg::*; (
	input  logic              clk,
	input  logic              cpu_reset,
	input  shift_mode_t       shift_mode,
	output logic              pixel_strobe,
	output logic [`CNT_W-1:0] hcnt,
	output logic [`CNT_W-1:0] vcnt,
	output logic              blank,
	output logic              border,
	output logic              hs,
	output logic              vs,
	output logic              frame_reload,
	output logic              fetch_window
);

	logic [1:0]   div;
	video_state_t h_state;
	video_state_t v_state;
	logic         next_is_disp;

	// ----------------------------------------
	// pixel strobe, every 1, 2 or 4 clk
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset)
			div <= 2'd0;
		else
			div <= div + 2'd1;
	end

	always_comb begin
		case (shift_mode)
			SM_LOW:  pixel_strobe = (div == 2'd3);
			SM_MID:  pixel_strobe = div[0];
			default: pixel_strobe = 1'b1;
		endcase
	end

	// state decode, ends of right side and starts of left side
	always_comb begin
		if (hcnt <= `H_DISP_END)      h_state = ST_DISP;
		else if (hcnt <= `H_BORDER_R) h_state = ST_BORDER;
		else if (hcnt <= `H_BLANK_R)  h_state = ST_BLANK;
		else if (hcnt < `H_BLANK_L)   h_state = ST_SYNC;
		else if (hcnt < `H_BORDER_L)  h_state = ST_BLANK;
		else                          h_state = ST_BORDER;
		if (vcnt <= `V_DISP_END)      v_state = ST_DISP;
		else if (vcnt <= `V_BORDER_B) v_state = ST_BORDER;
		else if (vcnt <= `V_BLANK_B)  v_state = ST_BLANK;
		else if (vcnt < `V_BLANK_T)   v_state = ST_SYNC;
		else if (vcnt == `V_BLANK_T)  v_state = ST_BLANK;
		else                          v_state = ST_BORDER;
	end

	// sync counts as blank
	assign blank  = (h_state inside {ST_SYNC, ST_BLANK}) || (v_state inside {ST_SYNC, ST_BLANK});
	assign border = (h_state == ST_BORDER) || (v_state == ST_BORDER);

	// vcnt steps at hcnt == H_SYNC, so at the window start
	// vcnt still holds the line before the display line
	assign next_is_disp = (vcnt == `V_END) || (vcnt < `V_DISP_END);

	// first strobe after vcnt has stepped into the sync line
	assign frame_reload = pixel_strobe && (vcnt == `V_SYNC) && (hcnt == `H_SYNC + 10'd1);

	// ----------------------------------------
	// counters, sync and fetch window
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			hcnt         <= '0;
			vcnt         <= '0;
			hs           <= 1'b1;
			vs           <= 1'b1;
			fetch_window <= 1'b0;
		end else if (pixel_strobe) begin
			hcnt <= (hcnt == `H_END) ? '0 : hcnt + 10'd1;
			if (hcnt == `H_SYNC)
				vcnt <= (vcnt == `V_END) ? '0 : vcnt + 10'd1;
			// active low, one strobe late like the rgb outputs
			hs <= !((hcnt >= `H_SYNC) && (hcnt < `H_BLANK_L));
			vs <= !((vcnt >= `V_SYNC) && (vcnt < `V_BLANK_T));
			// window covers 16 pixels before and the first half of the line
			if (hcnt == `H_END - `FETCH_AHEAD)
				fetch_window <= next_is_disp;
			else if (hcnt == `H_DISP_END - `FETCH_AHEAD)
				fetch_window <= 1'b0;
		end
	end

endmodule

// File: logic/video_regs.sv
// video shifter register file
// base address, shift mode and 16 entry palette on the cpu bus,
// plus read back of the video address counter
`timescale 1ns/100ps
`include "shifter_defines.svh"

module video_regs import shifter_regs_pkg::*; (
	input  logic                clk,
	input  logic                cpu_reset,
	input  logic                cpu_sel,
	input  logic                cpu_rw,
	input  logic [5:0]          cpu_addr,
	input  logic [15:0]         cpu_din,
	input  logic                cpu_uds,
	input  logic                cpu_lds,
	input  logic [`VADDR_W-1:0] vaddr,
	input  logic [3:0]          color_index,
	output logic [15:0]         cpu_dout,
	output logic [`VADDR_W-1:0] base_addr,
	output shift_mode_t         shift_mode,
	output pal_entry_t          pal_out,
	output logic                pal0_blue_lsb
);

	pal_entry_t palette [16];
	pal_entry_t rd_entry;
	logic       wr;
	logic       pal_sel;

	// single cycle select, rw low means write
	assign wr      = cpu_sel && !cpu_rw;
	assign pal_sel = (cpu_addr >= `PAL_FIRST) && (cpu_addr <= `PAL_LAST);

	// ----------------------------------------
	// register writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			base_addr  <= `BASE_RESET;
			shift_mode <= `SHMODE_RESET;
		end else if (wr) begin
			// base bytes live in the low data byte
			if (!cpu_lds && cpu_addr == `BASE_HI) begin
				base_addr[22:15] <= cpu_din[7:0];
				base_addr[6:0]   <= 7'h00;
			end
			if (!cpu_lds && cpu_addr == `BASE_MID) begin
				base_addr[14:7] <= cpu_din[7:0];
				base_addr[6:0]  <= 7'h00;
			end
			// mode sits in the high data byte
			if (!cpu_uds && cpu_addr == `SHMODE)
				shift_mode <= shift_mode_t'(cpu_din[9:8]);
		end
	end

	// palette, red in upper byte, green and blue in lower byte
	always_ff @(posedge clk) begin
		if (wr && pal_sel) begin
			if (!cpu_uds)
				palette[cpu_addr[3:0]].r <= cpu_din[10:8];
			if (!cpu_lds) begin
				palette[cpu_addr[3:0]].g <= cpu_din[6:4];
				palette[cpu_addr[3:0]].b <= cpu_din[2:0];
			end
		end
	end

	// second read port for the pixel path
	assign pal_out       = palette[color_index];
	// mono invert bit
	assign pal0_blue_lsb = palette[0].b[0];

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	assign rd_entry = palette[cpu_addr[3:0]];

	always_comb begin
		cpu_dout = 16'h0000;
		if (cpu_sel && cpu_rw) begin
			if (pal_sel) begin
				// unused msb of each nibble reads 0
				cpu_dout = {4'h0, 1'b0, rd_entry.r, 1'b0, rd_entry.g, 1'b0, rd_entry.b};
			end else begin
				case (cpu_addr)
					`BASE_HI:   cpu_dout = {8'h00, base_addr[22:15]};
					`BASE_MID:  cpu_dout = {8'h00, base_addr[14:7]};
					`VADDR_HI:  cpu_dout = {8'h00, vaddr[22:15]};
					`VADDR_MID: cpu_dout = {8'h00, vaddr[14:7]};
					// word address shown as byte address
					`VADDR_LO:  cpu_dout = {8'h00, vaddr[6:0], 1'b0};
					`SHMODE:    cpu_dout = {6'h00, shift_mode, 8'h00};
					default:    cpu_dout = 16'h0000;
				endcase
			end
		end
	end

endmodule

// File: logic/shifter_timing_pkg.sv
// timing side types of the video shifter
// video states and the plane number
package shifter_timing_pkg;

	// per-axis video state, same order as the old shifter
	typedef enum logic [1:0] {
		ST_SYNC   = 2'd0,
		ST_BLANK  = 2'd1,
		ST_BORDER = 2'd2,
		ST_DISP   = 2'd3
	} video_state_t;

	// plane number inside a 16 pixel group
	typedef logic [1:0] plane_idx_t;

endpackage

// File: logic/shifter_regs_pkg.sv
// register side types of the video shifter
// shift mode encoding and palette entry layout
package shifter_regs_pkg;

	// ----------------------------------------
	// shift mode, as held in the shmode register
	// ----------------------------------------
	typedef enum logic [1:0] {
		// 320 pixels, 4 planes
		SM_LOW  = 2'd0,
		// 640 pixels, 2 planes
		SM_MID  = 2'd1,
		// 640 pixels, 1 plane, mono monitor
		SM_MONO = 2'd2
	} shift_mode_t;

	// one palette entry, 3 bits per channel
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} pal_entry_t;

endpackage

// File: logic/shifter_defines.svh
// video shifter constants
// frame timing, bus widths, register map and reset values
`ifndef SHIFTER_DEFINES_SVH
`define SHIFTER_DEFINES_SVH

// bus and counter widths
`define CNT_W   10
`define VADDR_W 23
`define WORD_W  16

// horizontal change points, in pixels of the current mode
`define H_DISP_END 10'd31
`define H_BORDER_R 10'd35
`define H_BLANK_R  10'd39
`define H_SYNC     10'd40
`define H_BLANK_L  10'd44
`define H_BORDER_L 10'd48
`define H_END      10'd55

// vertical change points, in lines
`define V_DISP_END 10'd3
`define V_BORDER_B 10'd5
`define V_BLANK_B  10'd6
`define V_SYNC     10'd7
`define V_BLANK_T  10'd8
`define V_END      10'd9

// fetch lead ahead of the display
`define FETCH_AHEAD 10'd16

// register word addresses
`define BASE_HI   6'h00
`define BASE_MID  6'h01
`define VADDR_HI  6'h02
`define VADDR_MID 6'h03
`define VADDR_LO  6'h04
`define PAL_FIRST 6'h20
`define PAL_LAST  6'h2F
`define SHMODE    6'h30

// reset values
`define BASE_RESET   23'h008000
`define SHMODE_RESET SM_MONO

`endif
